//--- flist.f
+incdir+.
tcls_core_pkg.sv
tcls_reg_pkg.sv
tcls_reg_if.sv
tmr_voter.sv
tcls_vote_stage.sv
tcls_mode_fsm.sv
mismatch_counter.sv
tcls_regs.sv
tcls_unit.sv
tcls_checker.sv
tb_tcls_unit.sv

//--- mismatch_counter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Three saturating fault counters, one per core
// Only faults that are one-hot to a core are counted
// A clear strobe wins over an increment in the same cycle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "tcls_defines.svh"

module mismatch_counter (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   count_en_i,
  input  logic [2:0]             err_cba_i,
  input  logic                   clear_i [3],
  output logic [`TCLS_CNT_W-1:0] count_o [3]
);

  for (genvar i = 0; i < 3; i++) begin : gen_cnt
    logic                   hit;
    logic [`TCLS_CNT_W-1:0] cnt_q;

    assign hit = count_en_i && (err_cba_i == (3'b001 << i));

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        cnt_q <= '0;
      end else if (clear_i[i]) begin
        cnt_q <= '0;
      end else if (hit && (cnt_q != '1)) begin
        cnt_q <= cnt_q + 1'b1;
      end
    end

    assign count_o[i] = cnt_q;
  end

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# Build the TCLS testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f flist.f \
  --top-module tb_tcls_unit -o tb_tcls_unit
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/tb_tcls_unit)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "Test passed"; then
  exit 0
fi
exit 1

//--- tb_tcls_unit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Directed testbench for tcls_unit
// Inputs change on the rising edge, outputs are sampled on the falling edge
// Random payloads come from a 17-bit Fibonacci LFSR with a fixed seed
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "tcls_defines.svh"

module tb_tcls_unit;

  import tcls_core_pkg::*;

  localparam int CLK_PERIOD  = 100;
  // Rough cycle count of all tests
  localparam int TEST_CYCLES = 300;
  // Watchdog allows twice that
  localparam int WATCHDOG_NS = 2 * TEST_CYCLES * CLK_PERIOD;
  localparam int CNT_MAX     = (1 << `TCLS_CNT_W) - 1;

  logic                    clk_i = 1'b0;
  logic                    rst_ni;
  logic                    reg_valid_i;
  logic                    reg_write_i;
  logic [`TCLS_REG_AW-1:0] reg_addr_i;
  logic [`TCLS_DATA_W-1:0] reg_wdata_i;
  logic [`TCLS_DATA_W-1:0] reg_rdata_o;
  logic                    reg_ready_o;
  logic                    reg_error_o;
  logic                    fetch_en_i;
  logic                    core_irq_ack_i    [3];
  logic [4:0]              core_irq_ack_id_i [3];
  logic                    core_instr_req_i  [3];
  logic [`TCLS_ADDR_W-1:0] core_instr_addr_i [3];
  logic                    core_data_req_i   [3];
  logic [`TCLS_ADDR_W-1:0] core_data_addr_i  [3];
  logic                    core_data_we_i    [3];
  logic [`TCLS_DATA_W-1:0] core_data_wdata_i [3];
  logic [`TCLS_BE_W-1:0]   core_data_be_i    [3];
  logic                    irq_ack_o;
  logic [4:0]              irq_ack_id_o;
  logic                    instr_req_o;
  logic [`TCLS_ADDR_W-1:0] instr_addr_o;
  logic                    data_req_o;
  logic [`TCLS_ADDR_W-1:0] data_addr_o;
  logic                    data_we_o;
  logic [`TCLS_DATA_W-1:0] data_wdata_o;
  logic [`TCLS_BE_W-1:0]   data_be_o;
  logic                    triple_mismatch_o;
  logic [2:0]              single_mismatch_o;

  tcls_main_t  cur_main [3];
  tcls_data_t  cur_data [3];
  tcls_main_t  base_main;
  tcls_data_t  base_data;
  int          exp_cnt [3];
  int          errors = 0;
  int          tests = 0;
  logic [16:0] lfsr_q = 17'd76261;

  tcls_unit tcls_unit_inst (.*);

  bind tcls_unit tcls_checker checker_inst (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .valid_i   (reg_valid_i),
    .ready_i   (reg_ready_o),
    .triple_i  (triple_mismatch_o),
    .single_i  (single_mismatch_o),
    .irq_ack_i (irq_ack_o),
    .mode_i    (mode)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  // Taps 17 and 14 give a maximal-length sequence
  function automatic logic next_bit();
    logic fb;
    fb     = lfsr_q[16] ^ lfsr_q[13];
    lfsr_q = {lfsr_q[15:0], fb};
    return fb;
  endfunction

  task automatic rand_vec(input int n, output logic [68:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[67:0], next_bit()};
    end
  endtask

  function automatic tcls_main_t voted_main();
    return {irq_ack_o, irq_ack_id_o, instr_req_o, instr_addr_o, data_req_o};
  endfunction

  function automatic tcls_data_t voted_data();
    return {data_addr_o, data_we_o, data_wdata_o, data_be_o};
  endfunction

  // MODE register: restore_mode in bit 0, live mode in bits 3:2
  function automatic logic [31:0] mode_word(input logic restore, input red_mode_e m);
    logic [31:0] w;
    w      = '0;
    w[0]   = restore;
    w[3:2] = m;
    return w;
  endfunction

  task automatic report_value(input string name, input logic [68:0] got,
                              input logic [68:0] exp);
    $display("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
    errors++;
  endtask

  task automatic end_test(input string name, input int e0);
    tests++;
    $display("%-24s %s", name, (errors == e0) ? "ok" : "has errors");
  endtask

  task automatic bump(input int k);
    if (exp_cnt[k] < CNT_MAX) begin
      exp_cnt[k]++;
    end
  endtask

  task automatic set_all(input tcls_main_t m, input tcls_data_t d);
    for (int i = 0; i < 3; i++) begin
      cur_main[i] = m;
      cur_data[i] = d;
    end
  endtask

  task automatic apply_cores();
    @(posedge clk_i);
    for (int i = 0; i < 3; i++) begin
      core_irq_ack_i[i]    <= cur_main[i].irq_ack;
      core_irq_ack_id_i[i] <= cur_main[i].irq_ack_id;
      core_instr_req_i[i]  <= cur_main[i].instr_req;
      core_instr_addr_i[i] <= cur_main[i].instr_addr;
      core_data_req_i[i]   <= cur_main[i].data_req;
      core_data_addr_i[i]  <= cur_data[i].data_addr;
      core_data_we_i[i]    <= cur_data[i].data_we;
      core_data_wdata_i[i] <= cur_data[i].data_wdata;
      core_data_be_i[i]    <= cur_data[i].data_be;
    end
    @(negedge clk_i);
  endtask

  task automatic fresh_payload();
    logic [68:0] v;
    rand_vec(40, v);
    base_main = tcls_main_t'(v[39:0]);
    rand_vec(69, v);
    base_data = tcls_data_t'(v);
    set_all(base_main, base_data);
  endtask

  // One random main-payload bit differs on core k
  task automatic flip_core(input int k);
    logic [68:0] v;
    rand_vec(6, v);
    cur_main[k] = tcls_main_t'(base_main ^ (40'b1 << (v % 40)));
    apply_cores();
  endtask

  task automatic reg_access(input logic wr, input logic [4:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    @(posedge clk_i);
    reg_valid_i <= 1'b1;
    reg_write_i <= wr;
    reg_addr_i  <= addr;
    reg_wdata_i <= wdata;
    @(negedge clk_i);
    if (reg_ready_o !== 1'b1) begin
      $display("Register access at offset 0x%0h got no ready", addr);
      errors++;
    end
    rdata = reg_rdata_o;
    err   = reg_error_o;
    @(posedge clk_i);
    reg_valid_i <= 1'b0;
    reg_write_i <= 1'b0;
  endtask

  task automatic write_reg(input logic [4:0] addr, input logic [31:0] wdata);
    logic [31:0] rd;
    logic        err;
    reg_access(1'b1, addr, wdata, rd, err);
    if (err !== 1'b0) report_value("reg_error_o", err, 0);
  endtask

  task automatic expect_reg(input logic [4:0] addr, input logic [31:0] exp, input string name);
    logic [31:0] rd;
    logic        err;
    reg_access(1'b0, addr, '0, rd, err);
    if (rd !== exp) report_value(name, rd, exp);
    if (err !== 1'b0) report_value("reg_error_o", err, 0);
  endtask

  task automatic expect_counters();
    expect_reg(`TCLS_OFS_MISMATCH0, exp_cnt[0], "MISMATCH0");
    expect_reg(`TCLS_OFS_MISMATCH1, exp_cnt[1], "MISMATCH1");
    expect_reg(`TCLS_OFS_MISMATCH2, exp_cnt[2], "MISMATCH2");
  endtask

  // fetch_en_i low for one cycle forces TMR_RUN
  task automatic pulse_fetch_en();
    @(posedge clk_i);
    fetch_en_i <= 1'b0;
    @(posedge clk_i);
    fetch_en_i <= 1'b1;
    @(negedge clk_i);
  endtask

  task automatic test_reset_values();
    int e0;
    e0 = errors;
    expect_reg(`TCLS_OFS_MODE, mode_word(1'b0, TMR_RUN), "MODE");
    expect_reg(`TCLS_OFS_SP_STORE, '0, "SP_STORE");
    expect_counters();
    end_test("reset values", e0);
  endtask

  task automatic test_identical();
    int e0;
    e0 = errors;
    for (int r = 0; r < 4; r++) begin
      fresh_payload();
      apply_cores();
      if (voted_main() !== base_main) report_value("main outputs", voted_main(), base_main);
      if (voted_data() !== base_data) report_value("data outputs", voted_data(), base_data);
      if (triple_mismatch_o !== 1'b0) report_value("triple_mismatch_o", triple_mismatch_o, 0);
      if (single_mismatch_o !== 3'b000) report_value("single_mismatch_o", single_mismatch_o, 0);
    end
    end_test("identical payloads", e0);
  endtask

  task automatic test_single_fault();
    int e0;
    e0 = errors;
    for (int k = 0; k < 3; k++) begin
      fresh_payload();
      base_main.irq_ack    = 1'b1;
      base_main.irq_ack_id = 5'h15;
      set_all(base_main, base_data);
      flip_core(k);
      if (voted_main() !== base_main) report_value("main outputs", voted_main(), base_main);
      if (single_mismatch_o !== (3'b001 << k))
        report_value("single_mismatch_o", single_mismatch_o, 3'b001 << k);
      if (triple_mismatch_o !== 1'b1) report_value("triple_mismatch_o", triple_mismatch_o, 1);
      bump(k);
      set_all(base_main, base_data);
      apply_cores();
      // Now in TMR_UNLOAD with every core acknowledging
      if (irq_ack_o !== 1'b0) report_value("irq_ack_o", irq_ack_o, 0);
      if (irq_ack_id_o !== 5'h00) report_value("irq_ack_id_o", irq_ack_id_o, 0);
      expect_counters();
      expect_reg(`TCLS_OFS_MODE, mode_word(1'b0, TMR_UNLOAD), "MODE");
      pulse_fetch_en();
    end
    end_test("single-core fault", e0);
  endtask

  task automatic test_unload_reload();
    int e0;
    e0 = errors;
    fresh_payload();
    flip_core(1);
    bump(1);
    set_all(base_main, base_data);
    apply_cores();
    expect_reg(`TCLS_OFS_MODE, mode_word(1'b0, TMR_UNLOAD), "MODE");
    write_reg(`TCLS_OFS_SP_STORE, 32'h0001_F3C0);
    expect_reg(`TCLS_OFS_MODE, mode_word(1'b0, TMR_RELOAD), "MODE");
    expect_reg(`TCLS_OFS_SP_STORE, 32'h0001_F3C0, "SP_STORE");
    write_reg(`TCLS_OFS_SP_STORE, '0);
    expect_reg(`TCLS_OFS_MODE, mode_word(1'b0, TMR_RUN), "MODE");
    flip_core(2);
    bump(2);
    set_all(base_main, base_data);
    apply_cores();
    expect_reg(`TCLS_OFS_MODE, mode_word(1'b0, TMR_UNLOAD), "MODE");
    pulse_fetch_en();
    expect_reg(`TCLS_OFS_MODE, mode_word(1'b0, TMR_RUN), "MODE");
    expect_counters();
    end_test("unload and reload", e0);
  endtask

  task automatic test_restore_counting();
    int          e0;
    logic [68:0] v;
    e0 = errors;
    write_reg(`TCLS_OFS_MODE, 32'h1);
    fresh_payload();
    flip_core(1);
    for (int c = 0; c < 5; c++) begin
      if (c > 0) @(negedge clk_i);
      if (single_mismatch_o !== 3'b010) report_value("single_mismatch_o", single_mismatch_o, 2);
      bump(1);
    end
    set_all(base_main, base_data);
    apply_cores();
    expect_counters();
    expect_reg(`TCLS_OFS_MODE, mode_word(1'b1, TMR_RUN), "MODE");
    // Idle data lines may differ without a flag
    base_main.data_req = 1'b0;
    set_all(base_main, base_data);
    rand_vec(6, v);
    cur_data[2] = tcls_data_t'(base_data ^ (69'b1 << (v % 69)));
    apply_cores();
    if (triple_mismatch_o !== 1'b0) report_value("triple_mismatch_o", triple_mismatch_o, 0);
    if (single_mismatch_o !== 3'b000) report_value("single_mismatch_o", single_mismatch_o, 0);
    if (voted_data() !== base_data) report_value("data outputs", voted_data(), base_data);
    set_all(base_main, base_data);
    apply_cores();
    expect_counters();
    write_reg(`TCLS_OFS_MODE, 32'h0);
    end_test("restore mode counting", e0);
  endtask

  task automatic test_triple_and_clear();
    int          e0;
    logic [31:0] rd;
    logic        err;
    e0 = errors;
    fresh_payload();
    cur_main[0] = tcls_main_t'(base_main ^ 40'h08);
    cur_main[1] = tcls_main_t'(base_main ^ 40'h10);
    cur_main[2] = tcls_main_t'(base_main ^ 40'h20);
    apply_cores();
    if (triple_mismatch_o !== 1'b1) report_value("triple_mismatch_o", triple_mismatch_o, 1);
    if (single_mismatch_o !== 3'b111) report_value("single_mismatch_o", single_mismatch_o, 7);
    if (voted_main() !== base_main) report_value("main outputs", voted_main(), base_main);
    set_all(base_main, base_data);
    apply_cores();
    expect_counters();
    pulse_fetch_en();
    write_reg(`TCLS_OFS_MISMATCH0, 32'h1);
    write_reg(`TCLS_OFS_MISMATCH1, 32'h1);
    write_reg(`TCLS_OFS_MISMATCH2, 32'h1);
    exp_cnt = '{0, 0, 0};
    expect_counters();
    reg_access(1'b0, 5'h14, '0, rd, err);
    if (err !== 1'b1) report_value("reg_error_o", err, 1);
    reg_access(1'b1, 5'h14, 32'h1, rd, err);
    if (err !== 1'b1) report_value("reg_error_o", err, 1);
    expect_reg(`TCLS_OFS_MODE, mode_word(1'b0, TMR_RUN), "MODE");
    end_test("triple fault and clear", e0);
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns before the tests finished", WATCHDOG_NS);
    $display("Test failed");
    $finish;
  end

  initial begin
    int total;
    rst_ni      = 1'b0;
    reg_valid_i = 1'b0;
    reg_write_i = 1'b0;
    reg_addr_i  = '0;
    reg_wdata_i = '0;
    fetch_en_i  = 1'b1;
    exp_cnt     = '{0, 0, 0};
    set_all('0, '0);
    for (int i = 0; i < 3; i++) begin
      core_irq_ack_i[i]    = 1'b0;
      core_irq_ack_id_i[i] = '0;
      core_instr_req_i[i]  = 1'b0;
      core_instr_addr_i[i] = '0;
      core_data_req_i[i]   = 1'b0;
      core_data_addr_i[i]  = '0;
      core_data_we_i[i]    = 1'b0;
      core_data_wdata_i[i] = '0;
      core_data_be_i[i]    = '0;
    end
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;
    test_reset_values();
    test_identical();
    test_single_fault();
    test_unload_reload();
    test_restore_counting();
    test_triple_and_clear();
    total = errors + tcls_unit_inst.checker_inst.fail_cnt;
    $display("%0d tests, %0d check errors, %0d assertion failures", tests, errors,
             tcls_unit_inst.checker_inst.fail_cnt);
    if (total == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tcls_checker.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Concurrent assertions bound into tcls_unit
// Checked on the rising clock edge, idle while reset is low
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module tcls_checker (
  input logic                     clk_i,
  input logic                     rst_ni,
  input logic                     valid_i,
  input logic                     ready_i,
  input logic                     triple_i,
  input logic [2:0]               single_i,
  input logic                     irq_ack_i,
  input tcls_core_pkg::red_mode_e mode_i
);

  import tcls_core_pkg::*;

  int fail_cnt = 0;

  ready_follows_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ready_i == valid_i)
    else begin
      fail_cnt++;
      $error("reg_ready_o does not follow reg_valid_i");
    end

  // A single-core flag implies the global mismatch flag
  single_implies_triple: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (single_i != 3'b000) |-> triple_i)
    else begin
      fail_cnt++;
      $error("single_mismatch_o set without triple_mismatch_o");
    end

  irq_gated_in_unload: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mode_i == TMR_UNLOAD) |-> !irq_ack_i)
    else begin
      fail_cnt++;
      $error("irq_ack_o high during TMR_UNLOAD");
    end

  never_non_tmr: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mode_i != NON_TMR)
    else begin
      fail_cnt++;
      $error("Mode register entered NON_TMR");
    end

endmodule

`default_nettype wire

//--- tcls_core_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Core-side payloads voted by the TCLS unit and the redundancy mode
// NON_TMR is reserved and never entered by the current FSM
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "tcls_defines.svh"

package tcls_core_pkg;

  // Main payload, always compared
  typedef struct packed {
    logic                    irq_ack;
    logic [4:0]              irq_ack_id;
    logic                    instr_req;
    logic [`TCLS_ADDR_W-1:0] instr_addr;
    logic                    data_req;
  } tcls_main_t;

  // Data payload, meaningful only with data_req high
  typedef struct packed {
    logic [`TCLS_ADDR_W-1:0] data_addr;
    logic                    data_we;
    logic [`TCLS_DATA_W-1:0] data_wdata;
    logic [`TCLS_BE_W-1:0]   data_be;
  } tcls_data_t;

  typedef enum logic [1:0] {
    NON_TMR,
    TMR_RUN,
    TMR_UNLOAD,
    TMR_RELOAD
  } red_mode_e;

endpackage

`default_nettype wire

//--- tcls_defines.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Widths and register offsets shared by the TCLS unit
// Offsets are byte addresses on a 5-bit register bus, word aligned
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef TCLS_DEFINES_SVH
`define TCLS_DEFINES_SVH

// System bus widths
`define TCLS_ADDR_W 32
`define TCLS_DATA_W 32
`define TCLS_BE_W   4

// Per-core fault counters
`define TCLS_CNT_W  8

// Register bus
`define TCLS_REG_AW        5
`define TCLS_OFS_MODE      5'h00
`define TCLS_OFS_SP_STORE  5'h04
`define TCLS_OFS_MISMATCH0 5'h08
`define TCLS_OFS_MISMATCH1 5'h0C
`define TCLS_OFS_MISMATCH2 5'h10

`endif

//--- tcls_mode_fsm.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Redundancy mode FSM of the TCLS unit, resets to TMR_RUN
// fetch_en_i low forces TMR_RUN over every other transition
// Counting is enabled only in TMR_RUN while an error is present
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module tcls_mode_fsm (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      any_err_i,
  input  logic                      fetch_en_i,
  input  tcls_reg_pkg::tcls_ctrl_t  ctrl_i,
  output tcls_core_pkg::red_mode_e  mode_o,
  output logic                      count_en_o
);

  import tcls_core_pkg::*;

  red_mode_e mode_d;
  red_mode_e mode_q;

  always_comb begin
    mode_d = mode_q;
    case (mode_q)
      TMR_RUN: begin
        // With restore_mode set, faults are only counted
        if (any_err_i && !ctrl_i.restore_mode) begin
          mode_d = TMR_UNLOAD;
        end
      end
      TMR_UNLOAD: begin
        // Software has saved the stack pointer
        if (ctrl_i.sp_store != '0) begin
          mode_d = TMR_RELOAD;
        end
      end
      TMR_RELOAD: begin
        if (ctrl_i.sp_store == '0) begin
          mode_d = TMR_RUN;
        end
      end
      default: mode_d = TMR_RUN;
    endcase

    // Cores not yet fetching start in lock-step
    if (!fetch_en_i) begin
      mode_d = TMR_RUN;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mode_q <= TMR_RUN;
    end else begin
      mode_q <= mode_d;
    end
  end

  assign mode_o     = mode_q;
  assign count_en_o = (mode_q == TMR_RUN) && any_err_i;

endmodule

`default_nettype wire

//--- tcls_reg_if.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register bus between host and the TCLS register file
// Plain levels, ready follows valid in the same cycle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "tcls_defines.svh"

interface tcls_reg_if;

  logic                    valid;
  logic                    write;
  logic [`TCLS_REG_AW-1:0] addr;
  logic [`TCLS_DATA_W-1:0] wdata;
  logic [`TCLS_DATA_W-1:0] rdata;
  logic                    ready;
  logic                    error;

  modport host (output valid, write, addr, wdata, input rdata, ready, error);

  modport device (input valid, write, addr, wdata, output rdata, ready, error);

endinterface

`default_nettype wire

//--- tcls_reg_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// TCLS register map: register indexes and control fields
// Unaligned or unmapped offsets decode to INVALID
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "tcls_defines.svh"

package tcls_reg_pkg;

  typedef enum logic [2:0] {
    MODE,
    SP_STORE,
    MISMATCH0,
    MISMATCH1,
    MISMATCH2,
    INVALID
  } tcls_reg_e;

  // Register values consumed by the mode FSM
  typedef struct packed {
    logic                    restore_mode;
    logic [`TCLS_DATA_W-1:0] sp_store;
  } tcls_ctrl_t;

endpackage

`default_nettype wire

//--- tcls_regs.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// TCLS register file on the register bus
// Reads are combinational, writes land on the next rising edge
// Unmapped or unaligned offsets raise error and change nothing
// Writing a MISMATCH register clears its counter
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "tcls_defines.svh"

module tcls_regs (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  tcls_reg_if.device               bus,
  input  tcls_core_pkg::red_mode_e mode_i,
  input  logic [`TCLS_CNT_W-1:0]   count_i [3],
  output tcls_reg_pkg::tcls_ctrl_t ctrl_o,
  output logic                     clear_o [3]
);

  import tcls_reg_pkg::*;

  tcls_reg_e               reg_idx;
  logic                    wr_en;
  logic                    restore_mode_q;
  logic [`TCLS_DATA_W-1:0] sp_store_q;

  always_comb begin
    case (bus.addr)
      `TCLS_OFS_MODE:      reg_idx = MODE;
      `TCLS_OFS_SP_STORE:  reg_idx = SP_STORE;
      `TCLS_OFS_MISMATCH0: reg_idx = MISMATCH0;
      `TCLS_OFS_MISMATCH1: reg_idx = MISMATCH1;
      `TCLS_OFS_MISMATCH2: reg_idx = MISMATCH2;
      default:             reg_idx = INVALID;
    endcase
  end

  assign wr_en     = bus.valid && bus.write && (reg_idx != INVALID);
  assign bus.ready = bus.valid;
  assign bus.error = bus.valid && (reg_idx == INVALID);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      restore_mode_q <= 1'b0;
      sp_store_q     <= '0;
    end else if (wr_en) begin
      if (reg_idx == MODE) begin
        restore_mode_q <= bus.wdata[0];
      end
      if (reg_idx == SP_STORE) begin
        sp_store_q <= bus.wdata;
      end
    end
  end

  // MODE holds restore_mode in bit 0 and the live mode in bits 3:2
  always_comb begin
    bus.rdata = '0;
    case (reg_idx)
      MODE: begin
        bus.rdata[0]   = restore_mode_q;
        bus.rdata[3:2] = mode_i;
      end
      SP_STORE:  bus.rdata = sp_store_q;
      MISMATCH0: bus.rdata[`TCLS_CNT_W-1:0] = count_i[0];
      MISMATCH1: bus.rdata[`TCLS_CNT_W-1:0] = count_i[1];
      MISMATCH2: bus.rdata[`TCLS_CNT_W-1:0] = count_i[2];
      default:   bus.rdata = '0;
    endcase
  end

  assign clear_o[0] = wr_en && (reg_idx == MISMATCH0);
  assign clear_o[1] = wr_en && (reg_idx == MISMATCH1);
  assign clear_o[2] = wr_en && (reg_idx == MISMATCH2);

  assign ctrl_o.restore_mode = restore_mode_q;
  assign ctrl_o.sp_store     = sp_store_q;

endmodule

`default_nettype wire

//--- tcls_unit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Triple-core lock-step unit between three cores and one system bus
// Voted outputs and mismatch flags are combinational from core inputs
// Grants, read data and other return paths are wired outside the unit
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "tcls_defines.svh"

module tcls_unit (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    reg_valid_i,
  input  logic                    reg_write_i,
  input  logic [`TCLS_REG_AW-1:0] reg_addr_i,
  input  logic [`TCLS_DATA_W-1:0] reg_wdata_i,
  output logic [`TCLS_DATA_W-1:0] reg_rdata_o,
  output logic                    reg_ready_o,
  output logic                    reg_error_o,
  input  logic                    fetch_en_i,
  input  logic                    core_irq_ack_i     [3],
  input  logic [4:0]              core_irq_ack_id_i  [3],
  input  logic                    core_instr_req_i   [3],
  input  logic [`TCLS_ADDR_W-1:0] core_instr_addr_i  [3],
  input  logic                    core_data_req_i    [3],
  input  logic [`TCLS_ADDR_W-1:0] core_data_addr_i   [3],
  input  logic                    core_data_we_i     [3],
  input  logic [`TCLS_DATA_W-1:0] core_data_wdata_i  [3],
  input  logic [`TCLS_BE_W-1:0]   core_data_be_i     [3],
  output logic                    irq_ack_o,
  output logic [4:0]              irq_ack_id_o,
  output logic                    instr_req_o,
  output logic [`TCLS_ADDR_W-1:0] instr_addr_o,
  output logic                    data_req_o,
  output logic [`TCLS_ADDR_W-1:0] data_addr_o,
  output logic                    data_we_o,
  output logic [`TCLS_DATA_W-1:0] data_wdata_o,
  output logic [`TCLS_BE_W-1:0]   data_be_o,
  output logic                    triple_mismatch_o,
  output logic [2:0]              single_mismatch_o
);

  import tcls_core_pkg::*;
  import tcls_reg_pkg::*;

  tcls_main_t             core_main [3];
  tcls_data_t             core_data [3];
  tcls_main_t             main_voted;
  tcls_data_t             data_voted;
  red_mode_e              mode;
  tcls_ctrl_t             ctrl;
  logic                   any_err;
  logic [2:0]             err_cba;
  logic                   count_en;
  logic                   clear [3];
  logic [`TCLS_CNT_W-1:0] count [3];

  tcls_reg_if reg_bus ();

  assign reg_bus.valid = reg_valid_i;
  assign reg_bus.write = reg_write_i;
  assign reg_bus.addr  = reg_addr_i;
  assign reg_bus.wdata = reg_wdata_i;
  assign reg_rdata_o   = reg_bus.rdata;
  assign reg_ready_o   = reg_bus.ready;
  assign reg_error_o   = reg_bus.error;

  // Gather each core's request lines into the voted payloads
  for (genvar i = 0; i < 3; i++) begin : gen_pack
    assign core_main[i] = '{irq_ack: core_irq_ack_i[i], irq_ack_id: core_irq_ack_id_i[i],
                            instr_req: core_instr_req_i[i], instr_addr: core_instr_addr_i[i],
                            data_req: core_data_req_i[i]};
    assign core_data[i] = '{data_addr: core_data_addr_i[i], data_we: core_data_we_i[i],
                            data_wdata: core_data_wdata_i[i], data_be: core_data_be_i[i]};
  end

  tcls_vote_stage vote_stage_inst (
    .core_main_i (core_main),
    .core_data_i (core_data),
    .mode_i      (mode),
    .main_o      (main_voted),
    .data_o      (data_voted),
    .any_err_o   (any_err),
    .err_cba_o   (err_cba)
  );

  tcls_mode_fsm mode_fsm_inst (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .any_err_i  (any_err),
    .fetch_en_i (fetch_en_i),
    .ctrl_i     (ctrl),
    .mode_o     (mode),
    .count_en_o (count_en)
  );

  mismatch_counter mismatch_counter_inst (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .count_en_i (count_en),
    .err_cba_i  (err_cba),
    .clear_i    (clear),
    .count_o    (count)
  );

  tcls_regs regs_inst (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .bus     (reg_bus),
    .mode_i  (mode),
    .count_i (count),
    .ctrl_o  (ctrl),
    .clear_o (clear)
  );

  assign irq_ack_o         = main_voted.irq_ack;
  assign irq_ack_id_o      = main_voted.irq_ack_id;
  assign instr_req_o       = main_voted.instr_req;
  assign instr_addr_o      = main_voted.instr_addr;
  assign data_req_o        = main_voted.data_req;
  assign data_addr_o       = data_voted.data_addr;
  assign data_we_o         = data_voted.data_we;
  assign data_wdata_o      = data_voted.data_wdata;
  assign data_be_o         = data_voted.data_be;
  assign triple_mismatch_o = any_err;
  assign single_mismatch_o = err_cba;

endmodule

`default_nettype wire

//--- tcls_vote_stage.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Votes main and data payloads of the three cores
// Data payload errors count only while the voted data_req is high
// Interrupt acknowledge is forced to zero during TMR_UNLOAD
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module tcls_vote_stage (
  input  tcls_core_pkg::tcls_main_t core_main_i [3],
  input  tcls_core_pkg::tcls_data_t core_data_i [3],
  input  tcls_core_pkg::red_mode_e  mode_i,
  output tcls_core_pkg::tcls_main_t main_o,
  output tcls_core_pkg::tcls_data_t data_o,
  output logic                      any_err_o,
  output logic [2:0]                err_cba_o
);

  import tcls_core_pkg::*;

  tcls_main_t main_voted;
  logic       main_err;
  logic [2:0] main_err_cba;
  logic       data_err;
  logic [2:0] data_err_cba;

  tmr_voter #(.payload_t(tcls_main_t)) main_voter (
    .a_i         (core_main_i[0]),
    .b_i         (core_main_i[1]),
    .c_i         (core_main_i[2]),
    .majority_o  (main_voted),
    .error_o     (main_err),
    .error_cba_o (main_err_cba)
  );

  tmr_voter #(.payload_t(tcls_data_t)) data_voter (
    .a_i         (core_data_i[0]),
    .b_i         (core_data_i[1]),
    .c_i         (core_data_i[2]),
    .majority_o  (data_o),
    .error_o     (data_err),
    .error_cba_o (data_err_cba)
  );

  // Idle data lines may legally differ between cores
  assign any_err_o = main_err | (main_voted.data_req & data_err);
  assign err_cba_o = main_err_cba | ({3{main_voted.data_req}} & data_err_cba);

  always_comb begin
    main_o = main_voted;
    if (mode_i == TMR_UNLOAD) begin
      main_o.irq_ack    = 1'b0;
      main_o.irq_ack_id = '0;
    end
  end

endmodule

`default_nettype wire

//--- tmr_voter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bitwise 2-of-3 majority voter over any packed payload type
// Purely combinational; bit 0 of error_cba_o belongs to core a
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module tmr_voter #(
  parameter type payload_t = logic
) (
  input  payload_t   a_i,
  input  payload_t   b_i,
  input  payload_t   c_i,
  output payload_t   majority_o,
  output logic       error_o,
  output logic [2:0] error_cba_o
);

  localparam int unsigned W = $bits(payload_t);

  logic [W-1:0] a;
  logic [W-1:0] b;
  logic [W-1:0] c;
  logic [W-1:0] maj;

  assign a = a_i;
  assign b = b_i;
  assign c = c_i;

  // Each bit takes the value that at least two cores agree on
  assign maj        = (a & b) | (a & c) | (b & c);
  assign majority_o = payload_t'(maj);

  // A core is flagged when any of its bits was outvoted
  assign error_cba_o[0] = |(a ^ maj);
  assign error_cba_o[1] = |(b ^ maj);
  assign error_cba_o[2] = |(c ^ maj);

  assign error_o = |error_cba_o;

endmodule

`default_nettype wire
